/* common/drive_pkg.sv */
package drive_pkg;

    // operating modes of the instrument drive
    // TR moves a set number of steps, TX sweeps while the phase is searched,
    // TP holds on the detuning target
    typedef enum logic [1:0] {
        MODE_TR = 2'd0,  // transport
        MODE_TX = 2'd1,  // search sweep
        MODE_TP = 2'd2   // tracking
    } drive_mode_t;

    // width of the signed motor position count
    localparam int POS_WIDTH = 32;

    // width of the measured phase and of the detuning target
    localparam int PHASE_WIDTH = 32;

    // shortest step period in clocks that the step generator will run with
    localparam int MIN_PERIOD = 2;

endpackage

/* common/drive_if.sv */
`timescale 1ns/1ps

// settings of the active mode, as registered by the mode selector
interface drive_if #(
    parameter int period_width = 32
);
    import drive_pkg::*;

    logic [period_width-1:0] period;    // clocks between step pulses
    logic                    dir;       // 1 steps up, 0 steps down
    logic                    enable;    // motor drive enable
    logic                    count_en;  // transport counting window
    drive_mode_t             mode;      // active mode

    modport source (
        output period,
        output dir,
        output enable,
        output count_en,
        output mode
    );

    modport gen (
        input period,
        input dir,
        input enable
    );

    modport count (
        input count_en
    );

endinterface

/* src/drive_mode_select.sv */
`timescale 1ns/1ps

module drive_mode_select #(
    parameter int period_width = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [period_width-1:0]          period_tr,
    input  logic [period_width-1:0]          period_tx,
    input  logic [period_width-1:0]          period_tp,
    input  logic                             dir_tr,
    input  logic                             dir_tx,
    input  logic                             dir_tp,
    input  logic                             drv_en_tr,
    input  logic                             drv_en_tx,
    input  logic                             drv_en_tp,
    input  logic                             counter_en_tr,
    input  logic                             syncpulse,
    input  logic [drive_pkg::PHASE_WIDTH-1:0] fi_phm,
    input  logic [drive_pkg::PHASE_WIDTH-1:0] detuning,
    drive_if.source                          drv
);
    import drive_pkg::*;

    drive_mode_t             mode_q;
    drive_mode_t             mode_d;
    logic [period_width-1:0] sel_period;
    logic                    sel_dir;
    logic                    sel_en;
    logic                    sel_count_en;

    // next mode from the current mode and the sampled inputs
    always_comb
    begin
        mode_d = mode_q;  // every mode holds when nothing fires
        case (mode_q)
            MODE_TR:
            begin
                if (syncpulse)
                    mode_d = MODE_TX;
            end
            MODE_TX:
            begin
                if (fi_phm == detuning)  // a syncpulse here changes nothing
                    mode_d = MODE_TP;
            end
            MODE_TP:
            begin
                if (fi_phm > detuning)  // lost the target, go back to searching
                    mode_d = MODE_TX;
            end
            default:
                mode_d = MODE_TR;
        endcase
    end

    // settings that belong to the mode about to become active
    always_comb
    begin
        case (mode_d)
            MODE_TX:
            begin
                sel_period   = period_tx;
                sel_dir      = dir_tx;
                sel_en       = drv_en_tx;
                sel_count_en = 1'b0;
            end
            MODE_TP:
            begin
                sel_period   = period_tp;
                sel_dir      = dir_tp;
                sel_en       = drv_en_tp;
                sel_count_en = 1'b0;
            end
            default:
            begin
                sel_period   = period_tr;
                sel_dir      = dir_tr;
                sel_en       = drv_en_tr;
                sel_count_en = counter_en_tr;  // only transport counts pulses
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mode_q       <= MODE_TR;
            drv.enable   <= 1'b0;
            drv.count_en <= 1'b0;
        end
        else
        begin
            mode_q       <= mode_d;
            drv.enable   <= sel_en;
            drv.count_en <= sel_count_en;
        end
    end

    // period and direction follow the selected mode on every clock
    always_ff @(posedge clk)
    begin
        drv.period <= sel_period;
        drv.dir    <= sel_dir;
    end

    assign drv.mode = mode_q;

endmodule

/* step_gen/step_gen.sv */
`timescale 1ns/1ps

module step_gen #(
    parameter int period_width = 32
) (
    input  logic clk,
    input  logic rst,
    drive_if.gen drv,
    output logic step,
    output logic step_dir
);
    import drive_pkg::*;

    logic                    active;
    logic                    running;
    logic [period_width-1:0] elapsed;     // clocks seen in the current interval
    logic [period_width-1:0] cur_period;  // period of the interval in progress

    // the timer runs only with the drive enabled and a usable period
    assign active = drv.enable && (drv.period >= period_width'(MIN_PERIOD));

    always_ff @(posedge clk)
    begin
        if (rst || !active)
        begin
            running <= 1'b0;
            elapsed <= '0;
            step    <= 1'b0;
        end
        else if (!running)
        begin
            // enable rose on the previous edge, so this is the second clock of the interval
            running    <= 1'b1;
            elapsed    <= period_width'(2);
            cur_period <= drv.period;
            step       <= 1'b0;
        end
        else if (elapsed == cur_period)
        begin
            elapsed    <= period_width'(1);
            cur_period <= drv.period;  // a new period starts with the next interval
            step       <= 1'b1;
        end
        else
        begin
            elapsed <= elapsed + 1'b1;
            step    <= 1'b0;
        end
    end

    // direction is captured on the same edge that raises the step
    always_ff @(posedge clk)
    begin
        if (active && running && (elapsed == cur_period))
            step_dir <= drv.dir;
    end

endmodule

/* src/step_counter.sv */
`timescale 1ns/1ps

module step_counter #(
    parameter int period_width = 32
) (
    input  logic                                  clk,
    input  logic                                  rst,
    drive_if.count                                drv,
    input  logic                                  step,
    input  logic                                  step_dir,
    input  logic [period_width-1:0]               pulse_number,
    output logic signed [drive_pkg::POS_WIDTH-1:0] position,
    output logic [period_width-1:0]               pulse_count,
    output logic                                  pulse_done
);

    logic [period_width-1:0] count_next;

    assign count_next = pulse_count + 1'b1;

    // position follows every step in every mode
    always_ff @(posedge clk)
    begin
        if (rst)
            position <= '0;
        else if (step)
        begin
            if (step_dir)
                position <= position + 1'b1;
            else
                position <= position - 1'b1;
        end
    end

    // transport pulses are counted only inside the window
    always_ff @(posedge clk)
    begin
        if (rst || !drv.count_en)
        begin
            pulse_count <= '0;
            pulse_done  <= 1'b0;
        end
        else if (step && !pulse_done)
        begin
            pulse_count <= count_next;
            if (count_next == pulse_number)
                pulse_done <= 1'b1;  // saturate here, later steps are not counted
        end
    end

endmodule

/* src/stepper_top.sv */
`timescale 1ns/1ps

module stepper_top #(
    parameter int period_width = 32
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [period_width-1:0]               period_tr,
    input  logic [period_width-1:0]               period_tx,
    input  logic [period_width-1:0]               period_tp,
    input  logic                                  dir_tr,
    input  logic                                  dir_tx,
    input  logic                                  dir_tp,
    input  logic                                  drv_en_tr,
    input  logic                                  drv_en_tx,
    input  logic                                  drv_en_tp,
    input  logic                                  counter_en_tr,
    input  logic                                  syncpulse,
    input  logic [drive_pkg::PHASE_WIDTH-1:0]      fi_phm,
    input  logic [drive_pkg::PHASE_WIDTH-1:0]      detuning,
    input  logic [period_width-1:0]               pulse_number,
    output drive_pkg::drive_mode_t                mode,
    output logic                                  step,
    output logic                                  step_dir,
    output logic signed [drive_pkg::POS_WIDTH-1:0] position,
    output logic [period_width-1:0]               pulse_count,
    output logic                                  pulse_done
);

    drive_if #(.period_width(period_width)) drv ();

    drive_mode_select #(.period_width(period_width)) u_mode_select (
        .clk           (clk),
        .rst           (rst),
        .period_tr     (period_tr),
        .period_tx     (period_tx),
        .period_tp     (period_tp),
        .dir_tr        (dir_tr),
        .dir_tx        (dir_tx),
        .dir_tp        (dir_tp),
        .drv_en_tr     (drv_en_tr),
        .drv_en_tx     (drv_en_tx),
        .drv_en_tp     (drv_en_tp),
        .counter_en_tr (counter_en_tr),
        .syncpulse     (syncpulse),
        .fi_phm        (fi_phm),
        .detuning      (detuning),
        .drv           (drv.source)
    );

    step_gen #(.period_width(period_width)) u_step_gen (
        .clk      (clk),
        .rst      (rst),
        .drv      (drv.gen),
        .step     (step),
        .step_dir (step_dir)
    );

    step_counter #(.period_width(period_width)) u_step_counter (
        .clk          (clk),
        .rst          (rst),
        .drv          (drv.count),
        .step         (step),
        .step_dir     (step_dir),
        .pulse_number (pulse_number),
        .position     (position),
        .pulse_count  (pulse_count),
        .pulse_done   (pulse_done)
    );

    assign mode = drv.mode;  // the selector's mode register seen from outside

endmodule

/* dv/stepper_tb.sv */
`timescale 1ns/1ps

module stepper_tb;
    import drive_pkg::*;

    localparam int period_width = 32;
    localparam int run_cycles = 120 + 20 + 180 + 230 + 220 + 150;  // sum of the test lengths
    localparam int margin_cycles = 200;

    logic clk = 1'b0;
    logic rst;
    logic [period_width-1:0] period_tr;
    logic [period_width-1:0] period_tx;
    logic [period_width-1:0] period_tp;
    logic dir_tr, dir_tx, dir_tp;
    logic drv_en_tr, drv_en_tx, drv_en_tp;
    logic counter_en_tr;
    logic syncpulse;
    logic [PHASE_WIDTH-1:0] fi_phm;
    logic [PHASE_WIDTH-1:0] detuning;
    logic [period_width-1:0] pulse_number;
    drive_mode_t mode;
    logic step;
    logic step_dir;
    logic signed [POS_WIDTH-1:0] position;
    logic [period_width-1:0] pulse_count;
    logic pulse_done;

    // reference model of the selector registers, the position and the pulse count
    drive_mode_t m_mode = MODE_TR;
    drive_mode_t m_next;
    logic m_en = 1'b0;
    logic m_cnt_en = 1'b0;
    logic m_dir = 1'b0;
    logic [period_width-1:0] m_period = '0;
    logic n_en;
    logic n_dir;
    logic [period_width-1:0] n_period;
    logic m_act_before = 1'b0;  // drive settings as they stood before the last edge
    logic m_dir_before = 1'b0;
    logic [period_width-1:0] m_period_before = '0;
    logic signed [POS_WIDTH-1:0] m_pos = '0;
    logic [period_width-1:0] m_cnt = '0;
    logic m_done = 1'b0;
    logic seen_step = 1'b0;
    logic seen_dir = 1'b0;
    int gap = 0;
    int gap_period = 0;
    logic gap_valid = 1'b0;

    int errors = 0;
    int test_err_start = 0;
    int pass_count = 0;
    int fail_count = 0;
    int step_total = 0;

    always #10 clk = ~clk;

    stepper_top #(.period_width(period_width)) DUT (
        .clk           (clk),
        .rst           (rst),
        .period_tr     (period_tr),
        .period_tx     (period_tx),
        .period_tp     (period_tp),
        .dir_tr        (dir_tr),
        .dir_tx        (dir_tx),
        .dir_tp        (dir_tp),
        .drv_en_tr     (drv_en_tr),
        .drv_en_tx     (drv_en_tx),
        .drv_en_tp     (drv_en_tp),
        .counter_en_tr (counter_en_tr),
        .syncpulse     (syncpulse),
        .fi_phm        (fi_phm),
        .detuning      (detuning),
        .pulse_number  (pulse_number),
        .mode          (mode),
        .step          (step),
        .step_dir      (step_dir),
        .position      (position),
        .pulse_count   (pulse_count),
        .pulse_done    (pulse_done)
    );

    task automatic report_mismatch(string msg);
        $display("[FAIL] %0t %s", $time, msg);
        errors = errors + 1;
    endtask

    function automatic drive_mode_t next_mode(drive_mode_t cur);
        drive_mode_t nxt;
        nxt = cur;
        if (cur == MODE_TR && syncpulse)
            nxt = MODE_TX;
        else if (cur == MODE_TX && fi_phm == detuning)
            nxt = MODE_TP;
        else if (cur == MODE_TP && fi_phm > detuning)
            nxt = MODE_TX;
        return nxt;
    endfunction

    always @(posedge clk)
    begin
        m_next = next_mode(m_mode);
        case (m_next)
            MODE_TX:
            begin
                n_en = drv_en_tx;
                n_dir = dir_tx;
                n_period = period_tx;
            end
            MODE_TP:
            begin
                n_en = drv_en_tp;
                n_dir = dir_tp;
                n_period = period_tp;
            end
            default:
            begin
                n_en = drv_en_tr;
                n_dir = dir_tr;
                n_period = period_tr;
            end
        endcase
        m_act_before <= m_en && (m_period >= 2);
        m_dir_before <= m_dir;
        m_period_before <= m_period;
        m_mode <= rst ? MODE_TR : m_next;
        m_en <= rst ? 1'b0 : n_en;
        m_cnt_en <= rst ? 1'b0 : (m_next == MODE_TR) && counter_en_tr;
        m_period <= n_period;
        m_dir <= n_dir;
        if (rst)
            m_pos <= '0;
        else if (seen_step)
            m_pos <= seen_dir ? m_pos + 1 : m_pos - 1;
        if (rst || !m_cnt_en)
        begin
            m_cnt <= '0;
            m_done <= 1'b0;
        end
        else if (seen_step && !m_done)
        begin
            m_cnt <= m_cnt + 1;
            if (m_cnt + 1 == pulse_number)
                m_done <= 1'b1;
        end
    end

    // outputs are compared half a cycle after the edge that set them
    always @(negedge clk)
    begin
        seen_step = step;
        seen_dir = step_dir;
        if (rst)
            gap_valid = 1'b0;
        else
        begin
            assert (mode == m_mode)
            else report_mismatch($sformatf("mode %0d, expected %0d", mode, m_mode));
            assert (position == m_pos)
            else report_mismatch($sformatf("position %0d, expected %0d", position, m_pos));
            assert (pulse_count == m_cnt && pulse_done == m_done)
            else report_mismatch($sformatf("pulse_count %0d done %b, expected %0d done %b",
                                           pulse_count, pulse_done, m_cnt, m_done));
            gap = gap + 1;
            if (!m_act_before)
                gap_valid = 1'b0;  // the timer was cleared, the next interval starts fresh
            if (step)
            begin
                assert (m_act_before)
                else report_mismatch("a step came while the drive was stopped");
                assert (step_dir == m_dir_before)
                else report_mismatch($sformatf("step_dir %b, expected %b", step_dir, m_dir_before));
                if (gap_valid)
                begin
                    assert (gap == gap_period)
                    else report_mismatch($sformatf("step gap %0d, expected %0d", gap, gap_period));
                end
                gap = 0;
                gap_period = int'(m_period_before);
                gap_valid = 1'b1;
                step_total = step_total + 1;
            end
        end
    end

    // a step lasts exactly one clock
    assert property (@(posedge clk) disable iff (rst) step |=> !step)
    else report_mismatch("step stayed high for more than one clock");

    assert property (@(posedge clk) disable iff (rst) pulse_done |-> pulse_count == pulse_number)
    else report_mismatch("pulse_done is set while pulse_count differs from pulse_number");

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(int n);
        repeat (n) next_cycle();
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic expect_mode(drive_mode_t want, string what);
        @(negedge clk);
        assert (mode == want)
        else report_mismatch($sformatf("%s gave mode %0d, expected %0d", what, mode, want));
        next_cycle();
    endtask

    task automatic end_test(string name);
        if (errors == test_err_start)
        begin
            $display("[PASS] %0t %s", $time, name);
            pass_count++;
        end
        else
        begin
            $display("[FAIL] %0t %s: %0d errors", $time, name, errors - test_err_start);
            fail_count++;
        end
        test_err_start = errors;
    endtask

    function automatic logic [period_width-1:0] random_period();
        return period_width'(2 + ($urandom % 11));
    endfunction

    initial
    begin
        int first_gap;
        int start_steps;
        int wait_count;
        logic signed [POS_WIDTH-1:0] held_pos;

        void'($urandom(32'ha5a7));
        rst = 1'b1;
        period_tr = random_period();
        period_tx = random_period();
        period_tp = random_period();
        dir_tr = 1'b1;
        dir_tx = 1'b0;
        dir_tp = 1'b1;
        drv_en_tr = 1'b1;
        drv_en_tx = 1'b1;
        drv_en_tp = 1'b1;
        counter_en_tr = 1'b0;
        syncpulse = 1'b0;
        detuning = ($urandom & 32'h7fff_ffff) | 32'h100;
        fi_phm = detuning - 1;
        pulse_number = '0;

        // 1. reset, then the first step
        repeat (15) @(posedge clk);
        @(negedge clk);
        assert (mode == MODE_TR && step == 1'b0)
        else report_mismatch("mode is not TR or a step came during reset");
        @(posedge clk);
        #1;
        rst = 1'b0;
        first_gap = 0;
        while (!step && first_gap < 40)
        begin
            @(negedge clk);
            first_gap++;
        end
        // counting starts half a cycle before the selector edge, then one full period
        assert (step && first_gap == int'(period_tr) + 2)
        else report_mismatch($sformatf("first step after %0d cycles, expected %0d",
                                       first_gap, int'(period_tr) + 2));
        next_cycle();
        idle(60);
        end_test("reset and first step");

        // 2. mode transitions
        syncpulse = 1'b1;
        next_cycle();
        syncpulse = 1'b0;
        expect_mode(MODE_TX, "syncpulse in TR");
        syncpulse = 1'b1;
        next_cycle();
        syncpulse = 1'b0;
        expect_mode(MODE_TX, "syncpulse in TX");
        fi_phm = detuning;
        next_cycle();
        expect_mode(MODE_TP, "phase equal to detuning in TX");
        idle(4);
        fi_phm = detuning + 1 + ($urandom % 100);
        next_cycle();
        expect_mode(MODE_TX, "phase above detuning in TP");
        end_test("mode transitions");

        // 3. step period and direction in each mode
        period_tr = random_period();
        period_tx = random_period();
        period_tp = random_period();
        dir_tr = 1'($urandom);
        dir_tx = 1'($urandom);
        dir_tp = 1'($urandom);
        fi_phm = detuning - 1;
        apply_reset();
        start_steps = step_total;
        idle(50);
        syncpulse = 1'b1;
        next_cycle();
        syncpulse = 1'b0;
        idle(50);
        fi_phm = detuning;
        idle(50);
        assert (step_total - start_steps >= 6)
        else report_mismatch("too few steps came to check the periods");
        end_test("period and direction per mode");

        // 4. transport pulse count
        period_tr = random_period();
        counter_en_tr = 1'b1;
        pulse_number = period_width'(3 + ($urandom % 6));
        apply_reset();
        wait_count = 0;
        while (!pulse_done && wait_count < (int'(pulse_number) + 2) * 14 + 20)
        begin
            next_cycle();
            wait_count++;
        end
        assert (pulse_done && pulse_count == pulse_number)
        else report_mismatch($sformatf("pulse_done never came, pulse_count %0d", pulse_count));
        idle(36);
        assert (pulse_count == pulse_number)
        else report_mismatch($sformatf("pulse_count moved on to %0d", pulse_count));
        syncpulse = 1'b1;
        next_cycle();
        syncpulse = 1'b0;
        idle(3);
        assert (pulse_count == '0 && !pulse_done)
        else report_mismatch("pulse count did not clear outside TR");
        counter_en_tr = 1'b0;
        end_test("transport pulse count");

        // 5. position across random direction changes
        period_tr = 2;
        apply_reset();
        start_steps = step_total;
        repeat (40)
        begin
            dir_tr = 1'($urandom);
            period_tr = period_width'(2 + ($urandom % 4));
            idle(5);
        end
        assert (step_total - start_steps >= 20)
        else report_mismatch("too few steps came to check the position");
        end_test("position and direction");

        // 6. stopped drive
        drv_en_tr = 1'b0;
        period_tr = 4;
        idle(3);
        held_pos = position;
        start_steps = step_total;
        idle(40);
        drv_en_tr = 1'b1;
        period_tr = 1;
        idle(40);
        period_tr = 0;
        idle(40);
        assert (step_total == start_steps && position == held_pos)
        else report_mismatch("steps came or the position moved while the drive was stopped");
        period_tr = 3;
        idle(20);
        assert (step_total > start_steps)
        else report_mismatch("the drive did not restart with a valid period");
        end_test("stopped drive");

        $display("tests passed %0d, tests failed %0d, errors %0d", pass_count, fail_count, errors);
        if (errors == 0 && fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        #((run_cycles + margin_cycles) * 20);
        $display("timeout: the tests did not finish within %0d cycles",
                 run_cycles + margin_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* sources.f */
common/drive_pkg.sv
common/drive_if.sv
src/drive_mode_select.sv
step_gen/step_gen.sv
src/step_counter.sv
src/stepper_top.sv
dv/stepper_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module stepper_tb \
		-f sources.f -Mdir obj_dir
	@out=$$(./obj_dir/Vstepper_tb); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
